//--- hw/scanconv_pkg.sv
`default_nettype none

package scanconv_pkg;

    // ========================================
    // video
    // ========================================

    localparam int COLOR_W = 8;  // bits per channel

    // red in the top byte, blue in the low byte
    typedef logic [3*COLOR_W-1:0] pixel_t;

    typedef logic [1:0] osd_color_t;  // palette index from the OSD generator

    // fixed OSD palette
    localparam pixel_t OSD_BLACK  = '0;
    localparam pixel_t OSD_BLUE   = {{COLOR_W{1'b0}}, {COLOR_W{1'b0}}, {COLOR_W{1'b1}}};
    localparam pixel_t OSD_YELLOW = {{COLOR_W{1'b1}}, {COLOR_W{1'b1}}, {COLOR_W{1'b0}}};
    localparam pixel_t OSD_WHITE  = '1;

    // ========================================
    // control
    // ========================================

    localparam int KEY_W = 2;

    typedef logic [KEY_W-1:0] key_t;  // active low buttons

    // hold time is 2**RESYNC_LED_W - 1 cycles of clk27
    localparam int RESYNC_LED_W = 8;

    typedef logic [RESYNC_LED_W-1:0] led_cnt_t;

endpackage

`default_nettype wire

//--- hw/pixel_if.sv
`timescale 1ns/1ns
`default_nettype none

// one pixel per clk27 cycle, no handshake
interface pixel_if import scanconv_pkg::*; ();

    pixel_t rgb;
    logic   hsync;
    logic   vsync;
    logic   de;  // active video

    // producer side
    modport src (
        output rgb,
        output hsync,
        output vsync,
        output de
    );

    // consumer side
    modport snk (
        input rgb,
        input hsync,
        input vsync,
        input de
    );

endinterface

`default_nettype wire

//--- hw/osd_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module osd_mixer import scanconv_pkg::*; (
    input  wire logic       clk27,
    input  wire logic       sys_reset_n,

    pixel_if.snk            pix_i,        // scaler output
    input  wire logic       osd_enable_i,
    input  wire osd_color_t osd_color_i,

    pixel_if.src            pix_o         // towards the transmitter
);

    pixel_t osd_rgb;   // palette lookup
    pixel_t mix_rgb;   // overlay result

    pixel_t s1_rgb;
    logic   s1_hsync;
    logic   s1_vsync;
    logic   s1_de;

    pixel_t s2_rgb;
    logic   s2_hsync;
    logic   s2_vsync;
    logic   s2_de;

    // ========================================
    // palette and overlay select
    // ========================================

    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = OSD_BLACK;
            2'd1:    osd_rgb = OSD_BLUE;
            2'd2:    osd_rgb = OSD_YELLOW;
            default: osd_rgb = OSD_WHITE;
        endcase
    end

    assign mix_rgb = osd_enable_i ? osd_rgb : pix_i.rgb;

    // ========================================
    // stage 1 and stage 2
    // ========================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            s1_rgb   <= '0;
            s1_hsync <= 1'b0;
            s1_vsync <= 1'b0;
            s1_de    <= 1'b0;
        end else begin
            s1_rgb   <= mix_rgb;
            s1_hsync <= pix_i.hsync;  // syncs pass untouched
            s1_vsync <= pix_i.vsync;
            s1_de    <= pix_i.de;
        end
    end

    // launch register for the transmitter pins
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            s2_rgb   <= '0;
            s2_hsync <= 1'b0;
            s2_vsync <= 1'b0;
            s2_de    <= 1'b0;
        end else begin
            s2_rgb   <= s1_rgb;
            s2_hsync <= s1_hsync;
            s2_vsync <= s1_vsync;
            s2_de    <= s1_de;
        end
    end

    assign pix_o.rgb   = s2_rgb;
    assign pix_o.hsync = s2_hsync;
    assign pix_o.vsync = s2_vsync;
    assign pix_o.de    = s2_de;

endmodule

`default_nettype wire

//--- hw/async_input_sync.sv
`timescale 1ns/1ns
`default_nettype none

module async_input_sync import scanconv_pkg::*; (
    input  wire logic clk27,
    input  wire logic sys_reset_n,

    input  wire key_t keys_i,           // active low, straight from the pins
    input  wire logic ir_rx_i,          // idles high
    input  wire logic resync_strobe_i,  // from the scaler

    output key_t      keys_o,
    output logic      ir_rx_o,
    output logic      resync_o
);

    key_t keys_sync1;
    key_t keys_sync2;
    logic ir_sync1;
    logic ir_sync2;
    logic resync_sync1;
    logic resync_sync2;

    // buttons and IR come up released / idle
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            keys_sync1 <= '1;
            keys_sync2 <= '1;
            ir_sync1   <= 1'b1;
            ir_sync2   <= 1'b1;
        end else begin
            keys_sync1 <= keys_i;
            keys_sync2 <= keys_sync1;
            ir_sync1   <= ir_rx_i;
            ir_sync2   <= ir_sync1;
        end
    end

    // strobe idles low
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_sync1 <= 1'b0;
            resync_sync2 <= 1'b0;
        end else begin
            resync_sync1 <= resync_strobe_i;
            resync_sync2 <= resync_sync1;
        end
    end

    assign keys_o   = keys_sync2;
    assign ir_rx_o  = ir_sync2;
    assign resync_o = resync_sync2;  // level only, edge found downstream

endmodule

`default_nettype wire

//--- hw/resync_led_timer.sv
`timescale 1ns/1ns
`default_nettype none

module resync_led_timer import scanconv_pkg::*; (
    input  wire logic clk27,
    input  wire logic sys_reset_n,

    input  wire logic resync_i,  // already synchronized
    output logic      led_o
);

    logic     resync_prev;
    logic     resync_rise;
    led_cnt_t hold_cnt;

    // ========================================
    // edge detect
    // ========================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_prev <= 1'b0;
        end else begin
            resync_prev <= resync_i;
        end
    end

    assign resync_rise = resync_i & ~resync_prev;

    // ========================================
    // hold counter
    // ========================================

    // a new edge restarts the full hold time
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hold_cnt <= '0;
        end else if (resync_rise) begin
            hold_cnt <= '1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign led_o = (hold_cnt != '0);  // lit while counting

endmodule

`default_nettype wire

//--- hw/scanconv_io_top.sv
`timescale 1ns/1ns
`default_nettype none

module scanconv_io_top import scanconv_pkg::*; (
    input  wire logic       clk27,        // system and pixel clock
    input  wire logic       sys_reset_n,

    // scaler video in
    input  wire pixel_t     sc_rgb_i,
    input  wire logic       sc_hsync_i,
    input  wire logic       sc_vsync_i,
    input  wire logic       sc_de_i,
    input  wire logic       osd_enable_i,
    input  wire osd_color_t osd_color_i,

    // asynchronous board inputs
    input  wire key_t       keys_i,
    input  wire logic       ir_rx_i,
    input  wire logic       resync_strobe_i,

    // transmitter video out
    output pixel_t          tx_rgb_o,
    output logic            tx_hsync_o,
    output logic            tx_vsync_o,
    output logic            tx_de_o,

    // synchronized controls and LED
    output key_t            keys_o,
    output logic            ir_rx_o,
    output logic            resync_led_o
);

    logic resync_sync;  // strobe level in the clk27 domain

    pixel_if pix_in ();
    pixel_if pix_out ();

    // ========================================
    // video path
    // ========================================

    assign pix_in.rgb   = sc_rgb_i;
    assign pix_in.hsync = sc_hsync_i;
    assign pix_in.vsync = sc_vsync_i;
    assign pix_in.de    = sc_de_i;

    osd_mixer osd_mixer_inst (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .pix_i        (pix_in),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .pix_o        (pix_out)
    );

    assign tx_rgb_o   = pix_out.rgb;
    assign tx_hsync_o = pix_out.hsync;
    assign tx_vsync_o = pix_out.vsync;
    assign tx_de_o    = pix_out.de;

    // ========================================
    // control path
    // ========================================

    async_input_sync async_input_sync_inst (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .keys_i          (keys_i),
        .ir_rx_i         (ir_rx_i),
        .resync_strobe_i (resync_strobe_i),
        .keys_o          (keys_o),
        .ir_rx_o         (ir_rx_o),
        .resync_o        (resync_sync)
    );

    resync_led_timer resync_led_timer_inst (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .resync_i    (resync_sync),
        .led_o       (resync_led_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_scanconv_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_scanconv_checker import scanconv_pkg::*; (
    input  wire logic   clk27,
    input  wire logic   sys_reset_n,

    // DUT inputs as driven
    input  wire logic   sc_hsync_i,
    input  wire logic   sc_vsync_i,
    input  wire logic   sc_de_i,
    input  wire pixel_t exp_rgb_i,        // expected tx_rgb_o, from the stimulus table
    input  wire key_t   keys_i,
    input  wire logic   ir_rx_i,
    input  wire logic   resync_strobe_i,

    // DUT outputs
    input  wire pixel_t tx_rgb_i,
    input  wire logic   tx_hsync_i,
    input  wire logic   tx_vsync_i,
    input  wire logic   tx_de_i,
    input  wire key_t   keys_out_i,
    input  wire logic   ir_rx_out_i,
    input  wire logic   resync_led_i,

    output int          error_count_o
);

    pixel_t     exp_rgb_d1;
    pixel_t     exp_rgb_d2;
    logic [2:0] sync_d1;      // {hsync, vsync, de}
    logic [2:0] sync_d2;
    key_t       keys_d1;
    key_t       keys_d2;
    logic       ir_d1;
    logic       ir_d2;
    logic [2:0] strobe_hist;  // [0] is the newest sample
    led_cnt_t   led_cnt;
    int         errors = 0;

    // ========================================
    // reference model, two cycles deep
    // ========================================

    always @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            exp_rgb_d1  <= '0;
            exp_rgb_d2  <= '0;
            sync_d1     <= '0;
            sync_d2     <= '0;
            keys_d1     <= '1;  // released
            keys_d2     <= '1;
            ir_d1       <= 1'b1;
            ir_d2       <= 1'b1;
            strobe_hist <= '0;
            led_cnt     <= '0;
        end else begin
            exp_rgb_d1  <= exp_rgb_i;
            exp_rgb_d2  <= exp_rgb_d1;
            sync_d1     <= {sc_hsync_i, sc_vsync_i, sc_de_i};
            sync_d2     <= sync_d1;
            keys_d1     <= keys_i;
            keys_d2     <= keys_d1;
            ir_d1       <= ir_rx_i;
            ir_d2       <= ir_d1;
            strobe_hist <= {strobe_hist[1:0], resync_strobe_i};
            // rise seen two samples back reloads the full hold
            if (strobe_hist[1] && !strobe_hist[2]) begin
                led_cnt <= '1;
            end else if (led_cnt != '0) begin
                led_cnt <= led_cnt - led_cnt_t'(1);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            errors++;
            $display("ERROR %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
        end
    endtask

    // outputs are settled half a cycle after the edge
    always @(negedge clk27) begin
        check_value("tx_rgb_o", 32'(exp_rgb_d2), 32'(tx_rgb_i));
        check_value("tx_hsync_o", 32'(sync_d2[2]), 32'(tx_hsync_i));
        check_value("tx_vsync_o", 32'(sync_d2[1]), 32'(tx_vsync_i));
        check_value("tx_de_o", 32'(sync_d2[0]), 32'(tx_de_i));
        check_value("keys_o", 32'(keys_d2), 32'(keys_out_i));
        check_value("ir_rx_o", 32'(ir_d2), 32'(ir_rx_out_i));
        check_value("resync_led_o", 32'(led_cnt != '0), 32'(resync_led_i));
    end

    assign error_count_o = errors;

endmodule

`default_nettype wire

//--- verification/tb_scanconv_io.sv
`timescale 1ns/1ns
`default_nettype none

module tb_scanconv_io import scanconv_pkg::*; ();

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRIVE_DELAY  = 1;
    localparam logic [31:0] LFSR_SEED    = 32'hd8a6_56f2;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam int          LED_DELAY    = 3;
    localparam int          LED_HOLD     = 255;
    localparam int          LED_TIMEOUT  = 400;

    typedef struct packed {
        logic       rnd;      // rgb from the LFSR
        pixel_t     rgb;
        logic       hsync;
        logic       vsync;
        logic       de;
        logic       osd_en;
        osd_color_t osd_col;
        key_t       keys;
        logic       ir;
        pixel_t     exp_rgb;  // tx_rgb_o two cycles later
    } stim_row_t;

    logic       clk27;
    logic       sys_reset_n;
    pixel_t     sc_rgb_i;
    logic       sc_hsync_i;
    logic       sc_vsync_i;
    logic       sc_de_i;
    logic       osd_enable_i;
    osd_color_t osd_color_i;
    key_t       keys_i;
    logic       ir_rx_i;
    logic       resync_strobe_i;
    pixel_t     tx_rgb_o;
    logic       tx_hsync_o;
    logic       tx_vsync_o;
    logic       tx_de_o;
    key_t       keys_o;
    logic       ir_rx_o;
    logic       resync_led_o;

    pixel_t      exp_rgb;
    pixel_t      rand_rgb;
    stim_row_t   row;
    stim_row_t   stim_table[$];
    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors = 0;
    int          wait_cycles;
    int          hold_cycles;

    scanconv_io_top scanconv_io_top_inst (.*);

    tb_scanconv_checker checker_inst (
        .clk27 (clk27), .sys_reset_n (sys_reset_n),
        .sc_hsync_i (sc_hsync_i), .sc_vsync_i (sc_vsync_i), .sc_de_i (sc_de_i),
        .exp_rgb_i (exp_rgb), .keys_i (keys_i), .ir_rx_i (ir_rx_i),
        .resync_strobe_i (resync_strobe_i),
        .tx_rgb_i (tx_rgb_o), .tx_hsync_i (tx_hsync_o), .tx_vsync_i (tx_vsync_o),
        .tx_de_i (tx_de_o), .keys_out_i (keys_o), .ir_rx_out_i (ir_rx_o),
        .resync_led_i (resync_led_o), .error_count_o (value_errors)
    );

    initial begin
        clk27 = 1'b0;
        forever #(CLK_PERIOD / 2) clk27 = ~clk27;
    end

    // ========================================
    // helpers
    // ========================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic next_cycle();
        @(posedge clk27);
        #DRIVE_DELAY;
    endtask

    // one LFSR step per bit
    task automatic random_rgb(output pixel_t value);
        value = '0;
        for (int b = 0; b < 3 * COLOR_W; b++) begin
            value = {value[3*COLOR_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic apply_row(input stim_row_t r);
        sc_rgb_i     = r.rgb;
        sc_hsync_i   = r.hsync;
        sc_vsync_i   = r.vsync;
        sc_de_i      = r.de;
        osd_enable_i = r.osd_en;
        osd_color_i  = r.osd_col;
        keys_i       = r.keys;
        ir_rx_i      = r.ir;
        exp_rgb      = r.exp_rgb;
    endtask

    task automatic load_table();
        // rnd rgb hs vs de osd col keys ir expected
        stim_table.push_back('{1'b0, 24'h000000, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b11, 1'b1, 24'h000000});
        stim_table.push_back('{1'b0, 24'h123456, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b10, 1'b1, 24'h123456});
        stim_table.push_back('{1'b0, 24'habcdef, 1'b0, 1'b1, 1'b1, 1'b0, 2'd3, 2'b10, 1'b0, 24'habcdef});
        stim_table.push_back('{1'b1, 24'h000000, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0, 2'b01, 1'b0, 24'h000000});
        stim_table.push_back('{1'b1, 24'h000000, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 2'b01, 1'b1, 24'h000000});
        stim_table.push_back('{1'b1, 24'h000000, 1'b0, 1'b0, 1'b1, 1'b0, 2'd2, 2'b00, 1'b0, 24'h000000});
        stim_table.push_back('{1'b1, 24'h000000, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 1'b1, 24'h000000});
        // overlay colours 0 to 3
        stim_table.push_back('{1'b0, 24'h5a5a5a, 1'b0, 1'b0, 1'b1, 1'b1, 2'd0, 2'b11, 1'b1, 24'h000000});
        stim_table.push_back('{1'b0, 24'h5a5a5a, 1'b1, 1'b0, 1'b1, 1'b1, 2'd1, 2'b11, 1'b0, 24'h0000ff});
        stim_table.push_back('{1'b0, 24'ha5a5a5, 1'b0, 1'b1, 1'b0, 1'b1, 2'd2, 2'b10, 1'b0, 24'hffff00});
        stim_table.push_back('{1'b0, 24'h000000, 1'b1, 1'b1, 1'b1, 1'b1, 2'd3, 2'b01, 1'b1, 24'hffffff});
        stim_table.push_back('{1'b1, 24'h000000, 1'b0, 1'b0, 1'b1, 1'b1, 2'd2, 2'b11, 1'b1, 24'hffff00});
        stim_table.push_back('{1'b1, 24'h000000, 1'b0, 1'b1, 1'b1, 1'b0, 2'd1, 2'b11, 1'b1, 24'h000000});
        stim_table.push_back('{1'b0, 24'hffffff, 1'b1, 1'b0, 1'b1, 1'b0, 2'd0, 2'b11, 1'b1, 24'hffffff});
    endtask

    task automatic pulse_strobe();
        resync_strobe_i = 1'b1;
        next_cycle();
        resync_strobe_i = 1'b0;
    endtask

    task automatic wait_led(input logic level, output int cycles);
        cycles = 0;
        while (resync_led_o !== level && cycles < LED_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (resync_led_o !== level) begin
            other_errors++;
            $display("timed out waiting for the resync LED to reach %0d", level);
        end
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial begin
        sc_rgb_i        = '0;
        sc_hsync_i      = 1'b0;
        sc_vsync_i      = 1'b0;
        sc_de_i         = 1'b0;
        osd_enable_i    = 1'b0;
        osd_color_i     = '0;
        keys_i          = '1;
        ir_rx_i         = 1'b1;
        resync_strobe_i = 1'b0;
        exp_rgb         = '0;
        sys_reset_n     = 1'b0;
        lfsr_state      = LFSR_SEED;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk27);
        #DRIVE_DELAY sys_reset_n = 1'b1;

        foreach (stim_table[i]) begin
            row = stim_table[i];
            if (row.rnd) begin
                random_rgb(rand_rgb);
                row.rgb = rand_rgb;
                if (!row.osd_en) row.exp_rgb = rand_rgb;  // passes straight through
            end
            apply_row(row);
            next_cycle();
        end
        apply_row(stim_table[0]);
        repeat (4) next_cycle();

        // single pulse
        pulse_strobe();
        wait_led(1'b1, wait_cycles);
        // the sampling edge is already behind us here
        if (wait_cycles != LED_DELAY - 1) begin
            other_errors++;
            $display("resync LED lit %0d cycles after the strobe instead of %0d",
                     wait_cycles + 1, LED_DELAY);
        end
        wait_led(1'b0, hold_cycles);
        if (hold_cycles != LED_HOLD) begin
            other_errors++;
            $display("resync LED stayed lit for %0d cycles instead of %0d", hold_cycles, LED_HOLD);
        end

        // second edge in the middle of the hold
        pulse_strobe();
        wait_led(1'b1, wait_cycles);
        repeat (100) next_cycle();
        pulse_strobe();
        wait_led(1'b0, hold_cycles);
        if (hold_cycles < LED_HOLD) begin
            other_errors++;
            $display("a second strobe edge did not restart the resync LED hold time");
        end

        // level held high, one edge only
        resync_strobe_i = 1'b1;
        wait_led(1'b1, wait_cycles);
        if (wait_cycles != LED_DELAY) begin
            other_errors++;
            $display("resync LED lit %0d cycles after the held strobe instead of %0d",
                     wait_cycles, LED_DELAY);
        end
        wait_led(1'b0, hold_cycles);
        if (hold_cycles != LED_HOLD) begin
            other_errors++;
            $display("held strobe kept the resync LED lit for %0d cycles", hold_cycles);
        end
        resync_strobe_i = 1'b0;
        repeat (4) next_cycle();

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/scanconv_pkg.sv
hw/pixel_if.sv
hw/osd_mixer.sv
hw/async_input_sync.sv
hw/resync_led_timer.sv
hw/scanconv_io_top.sv
verification/tb_scanconv_checker.sv
verification/tb_scanconv_io.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

TOP=tb_scanconv_io
BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="Testbench failed"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"
exit 0
